//--- files.f
+incdir+.
rv_core_pkg.sv
rv_mem_stage.sv
rv_dmem.sv
rv_wb.sv
rv_regfile.sv
rv_memwb_top.sv
tb_rv_memwb.sv

//--- tb_rv_memwb_vectors.svh
`ifndef TB_RV_MEMWB_VECTORS_SVH
`define TB_RV_MEMWB_VECTORS_SVH

// Columns: name, pc, instr, bubble, alu result or address, store data, exception in,
//          then expected wb_we, wb_dst, wb_r, wb_exception, wb_badaddr
task automatic load_vectors();
  // ALU results straight through
  add_row("addi_x5", 'h1000, make_instr(OPC_OP_IMM, 3'd0, 5'd5), 1'b0, 'h0000_1234, '0, '0,
          1'b1, 5'd5, 'h0000_1234, '0, 'h1000);
  add_row("add_x6", 'h1004, make_instr(OPC_OP, 3'd0, 5'd6), 1'b0, 'hdead_beef, '0, '0,
          1'b1, 5'd6, 'hdead_beef, '0, 'h1004);
  add_row("lui_x7", 'h1008, make_instr(OPC_LUI, 3'd0, 5'd7), 1'b0, 'h8765_4000, '0, '0,
          1'b1, 5'd7, 'h8765_4000, '0, 'h1008);
  // Word, halfword and byte stores
  add_row("sw_10", 'h100c, make_instr(OPC_STORE, 3'd2, 5'd0), 1'b0, 'h10, 'h8899_aabb, '0,
          1'b0, 5'd0, '0, '0, 'h100c);
  add_row("sh_16", 'h1010, make_instr(OPC_STORE, 3'd1, 5'd0), 1'b0, 'h16, 'h0000_f00d, '0,
          1'b0, 5'd0, '0, '0, 'h1010);
  add_row("sb_19", 'h1014, make_instr(OPC_STORE, 3'd0, 5'd0), 1'b0, 'h19, 'h0000_0081, '0,
          1'b0, 5'd0, '0, '0, 'h1014);
  // Loads back at several byte offsets
  add_row("lw_10", 'h1018, make_instr(OPC_LOAD, 3'd2, 5'd8), 1'b0, 'h10, '0, '0,
          1'b1, 5'd8, 'h8899_aabb, '0, 'h1018);
  add_row("lh_12", 'h101c, make_instr(OPC_LOAD, 3'd1, 5'd9), 1'b0, 'h12, '0, '0,
          1'b1, 5'd9, 'hffff_8899, '0, 'h101c);
  add_row("lhu_16", 'h1020, make_instr(OPC_LOAD, 3'd5, 5'd10), 1'b0, 'h16, '0, '0,
          1'b1, 5'd10, 'h0000_f00d, '0, 'h1020);
  add_row("lh_16", 'h1024, make_instr(OPC_LOAD, 3'd1, 5'd11), 1'b0, 'h16, '0, '0,
          1'b1, 5'd11, 'hffff_f00d, '0, 'h1024);
  add_row("lb_19", 'h1028, make_instr(OPC_LOAD, 3'd0, 5'd12), 1'b0, 'h19, '0, '0,
          1'b1, 5'd12, 'hffff_ff81, '0, 'h1028);
  add_row("lbu_19", 'h102c, make_instr(OPC_LOAD, 3'd4, 5'd13), 1'b0, 'h19, '0, '0,
          1'b1, 5'd13, 'h0000_0081, '0, 'h102c);
  add_row("lbu_11", 'h1030, make_instr(OPC_LOAD, 3'd4, 5'd14), 1'b0, 'h11, '0, '0,
          1'b1, 5'd14, 'h0000_00aa, '0, 'h1030);
  add_row("lb_13", 'h1034, make_instr(OPC_LOAD, 3'd0, 5'd15), 1'b0, 'h13, '0, '0,
          1'b1, 5'd15, 'hffff_ff88, '0, 'h1034);
  // Faulting accesses, bad address is the data address
  add_row("lh_mis", 'h1038, make_instr(OPC_LOAD, 3'd1, 5'd16), 1'b0, 'h21, '0, '0,
          1'b0, 5'd16, '0, cause_bit(`RV_CAUSE_MISALIGNED_LOAD), 'h21);
  add_row("sw_mis", 'h103c, make_instr(OPC_STORE, 3'd2, 5'd0), 1'b0, 'h22, 'h1, '0,
          1'b0, 5'd0, '0, cause_bit(`RV_CAUSE_MISALIGNED_STORE), 'h22);
  add_row("lw_oob", 'h1040, make_instr(OPC_LOAD, 3'd2, 5'd17), 1'b0, 'h100, '0, '0,
          1'b0, 5'd17, '0, cause_bit(`RV_CAUSE_LOAD_ACCESS_FAULT), 'h100);
  add_row("sw_guard", 'h1044, make_instr(OPC_STORE, 3'd2, 5'd0), 1'b0, 'h80, 'h1, '0,
          1'b0, 5'd0, '0, cause_bit(`RV_CAUSE_STORE_PAGE_FAULT), 'h80);
  add_row("lw_guard", 'h1048, make_instr(OPC_LOAD, 3'd2, 5'd18), 1'b0, 'h84, '0, '0,
          1'b0, 5'd18, '0, cause_bit(`RV_CAUSE_LOAD_PAGE_FAULT), 'h84);
  // Incoming exception skips memory
  add_row("exc_pass", 'h104c, make_instr(OPC_LOAD, 3'd2, 5'd19), 1'b0, 'h10, '0, cause_bit(2),
          1'b0, 5'd19, '0, cause_bit(2), 'h104c);
  // Bubble and x0 never write
  add_row("bubble", 'h1050, make_instr(OPC_OP_IMM, 3'd0, 5'd20), 1'b1, 'h5555, '0, '0,
          1'b0, 5'd20, '0, '0, 'h1050);
  add_row("addi_x0", 'h1054, make_instr(OPC_OP_IMM, 3'd0, 5'd0), 1'b0, 'h77, '0, '0,
          1'b0, 5'd0, '0, '0, 'h1054);
  add_row("lw_x0", 'h1058, make_instr(OPC_LOAD, 3'd2, 5'd0), 1'b0, 'h10, '0, '0,
          1'b0, 5'd0, '0, '0, 'h1058);
  add_row("add_x5", 'h105c, make_instr(OPC_OP, 3'd0, 5'd5), 1'b0, 'h5555_aaaa, '0, '0,
          1'b1, 5'd5, 'h5555_aaaa, '0, 'h105c);
endtask

`endif

//--- tb_rv_memwb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_macros.svh"

module tb_rv_memwb;

  import rv_core_pkg::*;

  localparam int CLK_HALF   = 4;
  localparam int DRIVE_DLY  = 1;
  localparam int RST_CYCLES = 5;
  localparam int SEED       = 67551;

  logic     clk_i;
  logic     rst_ni;
  xlen_t    ex_pc_i;
  instr_t   ex_instr_i;
  logic     ex_bubble_i;
  xlen_t    ex_r_i;
  xlen_t    ex_wdata_i;
  except_t  ex_exception_i;
  logic     stall_o;
  xlen_t    wb_pc_o;
  instr_t   wb_instr_o;
  logic     wb_bubble_o;
  except_t  wb_exception_o;
  xlen_t    wb_badaddr_o;
  reg_idx_t wb_dst_o;
  xlen_t    wb_r_o;
  logic     wb_we_o;
  reg_idx_t dbg_addr_i;
  xlen_t    dbg_data_o;

  // Table columns, one queue each
  string    names [$];
  xlen_t    pcs [$];
  instr_t   instrs [$];
  logic     bubbles [$];
  xlen_t    alu_rs [$];
  xlen_t    wdatas [$];
  except_t  excs [$];
  logic     exp_wes [$];
  reg_idx_t exp_dsts [$];
  xlen_t    exp_rs [$];
  except_t  exp_excs [$];
  xlen_t    exp_bads [$];

  // Expected register file contents
  xlen_t       reg_model [32];
  int          checked_rows  = 0;
  int          expected_rows = 0;
  int unsigned cycle_count   = 0;
  int unsigned cycle_limit   = 0;

  rv_memwb_top u_rv_memwb_top (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ex_pc_i        (ex_pc_i),
    .ex_instr_i     (ex_instr_i),
    .ex_bubble_i    (ex_bubble_i),
    .ex_r_i         (ex_r_i),
    .ex_wdata_i     (ex_wdata_i),
    .ex_exception_i (ex_exception_i),
    .stall_o        (stall_o),
    .wb_pc_o        (wb_pc_o),
    .wb_instr_o     (wb_instr_o),
    .wb_bubble_o    (wb_bubble_o),
    .wb_exception_o (wb_exception_o),
    .wb_badaddr_o   (wb_badaddr_o),
    .wb_dst_o       (wb_dst_o),
    .wb_r_o         (wb_r_o),
    .wb_we_o        (wb_we_o),
    .dbg_addr_i     (dbg_addr_i),
    .dbg_data_o     (dbg_data_o)
  );

  always #CLK_HALF clk_i = ~clk_i;

  ////////////////////
  // Encoding helpers
  ////////////////////

  // Only opcode, funct3 and rd matter past execute
  function automatic instr_t make_instr(input opcode_e opc, input funct3_t f3,
                                        input reg_idx_t rd);
    return {17'b0, f3, rd, opc, 2'b11};
  endfunction

  function automatic except_t cause_bit(input int idx);
    except_t v;
    v      = '0;
    v[idx] = 1'b1;
    return v;
  endfunction

  // Clean load or store, memory is touched
  function automatic logic needs_access(input instr_t instr, input logic bubble,
                                        input except_t exc);
    logic [4:0] opc;
    opc = instr[6:2];
    return !bubble && (exc == '0) && ((opc == OPC_LOAD) || (opc == OPC_STORE));
  endfunction

  task automatic add_row(input string name, input xlen_t pc, input instr_t instr,
                         input logic bubble, input xlen_t r, input xlen_t wdata,
                         input except_t exc, input logic we, input reg_idx_t dst,
                         input xlen_t exp_r, input except_t exp_exc, input xlen_t bad);
    names.push_back(name);
    pcs.push_back(pc);
    instrs.push_back(instr);
    bubbles.push_back(bubble);
    alu_rs.push_back(r);
    wdatas.push_back(wdata);
    excs.push_back(exc);
    exp_wes.push_back(we);
    exp_dsts.push_back(dst);
    exp_rs.push_back(exp_r);
    exp_excs.push_back(exp_exc);
    exp_bads.push_back(bad);
  endtask

  `include "tb_rv_memwb_vectors.svh"

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_xlen(input string test, input string what, input xlen_t exp,
                            input xlen_t act);
    if (act !== exp)
      fail_now($sformatf("[FAIL] %s %s: expected %h, actual %h", test, what, exp, act));
  endtask

  task automatic check_instr(input string test, input string what, input instr_t exp,
                             input instr_t act);
    if (act !== exp)
      fail_now($sformatf("[FAIL] %s %s: expected %h, actual %h", test, what, exp, act));
  endtask

  task automatic check_except(input string test, input string what, input except_t exp,
                              input except_t act);
    if (act !== exp)
      fail_now($sformatf("[FAIL] %s %s: expected %h, actual %h", test, what, exp, act));
  endtask

  task automatic check_idx(input string test, input string what, input reg_idx_t exp,
                           input reg_idx_t act);
    if (act !== exp)
      fail_now($sformatf("[FAIL] %s %s: expected %0d, actual %0d", test, what, exp, act));
  endtask

  task automatic check_bit(input string test, input string what, input logic exp,
                           input logic act);
    if (act !== exp)
      fail_now($sformatf("[FAIL] %s %s: expected %b, actual %b", test, what, exp, act));
  endtask

  // One retired instruction against its row
  task automatic compare_row(input int idx, input logic stall_seen);
    check_xlen(names[idx], "wb_pc", pcs[idx], wb_pc_o);
    check_instr(names[idx], "wb_instr", instrs[idx], wb_instr_o);
    check_bit(names[idx], "wb_we", exp_wes[idx], wb_we_o);
    check_idx(names[idx], "wb_dst", exp_dsts[idx], wb_dst_o);
    check_except(names[idx], "wb_exception", exp_excs[idx], wb_exception_o);
    check_xlen(names[idx], "wb_badaddr", exp_bads[idx], wb_badaddr_o);
    if (exp_wes[idx])
    begin
      check_xlen(names[idx], "wb_r", exp_rs[idx], wb_r_o);
      reg_model[exp_dsts[idx]] = exp_rs[idx];
    end
    // Stall only while a clean access is pending
    check_bit(names[idx], "stall", needs_access(instrs[idx], bubbles[idx], excs[idx]),
              stall_seen);
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  // Called just after a rising edge, returns just after the capturing edge
  task automatic drive_item(input xlen_t pc, input instr_t instr, input logic bubble,
                            input xlen_t r, input xlen_t wdata, input except_t exc);
    ex_pc_i        = pc;
    ex_instr_i     = instr;
    ex_bubble_i    = bubble;
    ex_r_i         = r;
    ex_wdata_i     = wdata;
    ex_exception_i = exc;
    // Stall is settled between the falling and rising edge
    @(negedge clk_i);
    while (stall_o)
      @(negedge clk_i);
    @(posedge clk_i);
    #DRIVE_DLY;
  endtask

  task automatic drive_idle();
    drive_item(`RV_PC_INIT, INSTR_NOP, 1'b1, '0, '0, '0);
  endtask

  // One register per cycle through the debug port
  task automatic dump_regs();
    for (int i = 0; i < 32; i++)
    begin
      @(posedge clk_i);
      #DRIVE_DLY;
      dbg_addr_i = i[4:0];
      @(negedge clk_i);
      check_xlen("regfile_dump", $sformatf("x%0d", i), reg_model[i], dbg_data_o);
    end
  endtask

  // Run limit from the table length
  always @(posedge clk_i)
  begin
    cycle_count = cycle_count + 1;
    if ((cycle_limit != 0) && (cycle_count >= cycle_limit))
      fail_now("Timeout, the pipeline did not retire all table rows in time");
  end

  ////////////////////
  // Monitor
  ////////////////////

  initial
  begin
    int   idx;
    logic loaded;
    logic stall_seen;
    idx        = 0;
    loaded     = 1'b0;
    stall_seen = 1'b0;
    wait (rst_ni === 1'b1);
    forever
    begin
      @(negedge clk_i);
      // Write-back took a new item on the last edge
      if (loaded)
      begin
        if (wb_bubble_o)
        begin
          check_bit("bubble", "wb_we", 1'b0, wb_we_o);
        end
        else
        begin
          while ((idx < names.size()) && bubbles[idx])
            idx++;
          if (idx >= names.size())
          begin
            fail_now("An instruction retired with no table row left to match");
          end
          else
          begin
            compare_row(idx, stall_seen);
            idx++;
            checked_rows++;
          end
        end
        stall_seen = 1'b0;
      end
      // Stall history of the item now in the memory stage
      stall_seen = stall_seen | stall_o;
      loaded     = !stall_o;
    end
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial
  begin
    int gap;
    void'($urandom(SEED));
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    ex_pc_i        = `RV_PC_INIT;
    ex_instr_i     = INSTR_NOP;
    ex_bubble_i    = 1'b1;
    ex_r_i         = '0;
    ex_wdata_i     = '0;
    ex_exception_i = '0;
    dbg_addr_i     = '0;
    for (int i = 0; i < 32; i++)
      reg_model[i] = '0;
    load_vectors();
    for (int i = 0; i < names.size(); i++)
    begin
      if (!bubbles[i])
        expected_rows++;
    end
    cycle_limit = names.size() * (`RV_DMEM_LATENCY + 6) + 50;
    repeat (RST_CYCLES) @(posedge clk_i);
    #DRIVE_DLY;
    rst_ni = 1'b1;
    for (int i = 0; i < names.size(); i++)
    begin
      drive_item(pcs[i], instrs[i], bubbles[i], alu_rs[i], wdatas[i], excs[i]);
      // Random idle gap before the next row
      gap = $urandom_range(2, 0);
      repeat (gap) drive_idle();
    end
    drive_idle();
    wait (checked_rows == expected_rows);
    // Let the last register write land
    repeat (2) @(posedge clk_i);
    #DRIVE_DLY;
    dump_regs();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- rv_memwb_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_memwb_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Execute stage
  input  rv_core_pkg::xlen_t    ex_pc_i,
  input  rv_core_pkg::instr_t   ex_instr_i,
  input  logic                  ex_bubble_i,
  input  rv_core_pkg::xlen_t    ex_r_i,
  input  rv_core_pkg::xlen_t    ex_wdata_i,
  input  rv_core_pkg::except_t  ex_exception_i,
  output logic                  stall_o,
  // Write-back view
  output rv_core_pkg::xlen_t    wb_pc_o,
  output rv_core_pkg::instr_t   wb_instr_o,
  output logic                  wb_bubble_o,
  output rv_core_pkg::except_t  wb_exception_o,
  output rv_core_pkg::xlen_t    wb_badaddr_o,
  output rv_core_pkg::reg_idx_t wb_dst_o,
  output rv_core_pkg::xlen_t    wb_r_o,
  output logic                  wb_we_o,
  // Register file debug
  input  rv_core_pkg::reg_idx_t dbg_addr_i,
  output rv_core_pkg::xlen_t    dbg_data_o
);

  import rv_core_pkg::*;

  // Memory stage to write-back
  xlen_t   mem_pc;
  instr_t  mem_instr;
  logic    mem_bubble;
  xlen_t   mem_r;
  xlen_t   mem_memadr;
  except_t mem_exception;

  // Data memory bus
  logic    dmem_req;
  logic    dmem_we;
  xlen_t   dmem_adr;
  funct3_t dmem_size;
  xlen_t   dmem_wdata;
  logic    dmem_ack;
  xlen_t   dmem_q;
  logic    dmem_err;
  logic    dmem_misaligned;
  logic    dmem_page_fault;

  rv_mem_stage u_mem_stage (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .ex_pc_i         (ex_pc_i),
    .ex_instr_i      (ex_instr_i),
    .ex_bubble_i     (ex_bubble_i),
    .ex_r_i          (ex_r_i),
    .ex_wdata_i      (ex_wdata_i),
    .ex_exception_i  (ex_exception_i),
    .stall_i         (stall_o),
    .mem_pc_o        (mem_pc),
    .mem_instr_o     (mem_instr),
    .mem_bubble_o    (mem_bubble),
    .mem_r_o         (mem_r),
    .mem_memadr_o    (mem_memadr),
    .mem_exception_o (mem_exception),
    .dmem_req_o      (dmem_req),
    .dmem_we_o       (dmem_we),
    .dmem_adr_o      (dmem_adr),
    .dmem_size_o     (dmem_size),
    .dmem_wdata_o    (dmem_wdata),
    .dmem_ack_i      (dmem_ack)
  );

  rv_dmem u_dmem (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .dmem_req_i        (dmem_req),
    .dmem_we_i         (dmem_we),
    .dmem_adr_i        (dmem_adr),
    .dmem_size_i       (dmem_size),
    .dmem_wdata_i      (dmem_wdata),
    .dmem_ack_o        (dmem_ack),
    .dmem_q_o          (dmem_q),
    .dmem_err_o        (dmem_err),
    .dmem_misaligned_o (dmem_misaligned),
    .dmem_page_fault_o (dmem_page_fault)
  );

  // Write-back stall is the upstream stall
  rv_wb u_wb (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .wb_stall_o        (stall_o),
    .mem_pc_i          (mem_pc),
    .mem_instr_i       (mem_instr),
    .mem_bubble_i      (mem_bubble),
    .mem_exception_i   (mem_exception),
    .mem_r_i           (mem_r),
    .mem_memadr_i      (mem_memadr),
    .dmem_ack_i        (dmem_ack),
    .dmem_err_i        (dmem_err),
    .dmem_q_i          (dmem_q),
    .dmem_misaligned_i (dmem_misaligned),
    .dmem_page_fault_i (dmem_page_fault),
    .wb_pc_o           (wb_pc_o),
    .wb_instr_o        (wb_instr_o),
    .wb_bubble_o       (wb_bubble_o),
    .wb_exception_o    (wb_exception_o),
    .wb_badaddr_o      (wb_badaddr_o),
    .wb_dst_o          (wb_dst_o),
    .wb_r_o            (wb_r_o),
    .wb_we_o           (wb_we_o)
  );

  rv_regfile u_regfile (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .we_i       (wb_we_o),
    .waddr_i    (wb_dst_o),
    .wdata_i    (wb_r_o),
    .dbg_addr_i (dbg_addr_i),
    .dbg_data_o (dbg_data_o)
  );

endmodule

`default_nettype wire

//--- rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Write port from write-back
  input  logic                  we_i,
  input  rv_core_pkg::reg_idx_t waddr_i,
  input  rv_core_pkg::xlen_t    wdata_i,
  // Debug read
  input  rv_core_pkg::reg_idx_t dbg_addr_i,
  output rv_core_pkg::xlen_t    dbg_data_o
);

  import rv_core_pkg::*;

  xlen_t regs [32];

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end
    // x0 is never written
    else if (we_i && (waddr_i != '0))
    begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // Combinational read, x0 reads zero
  assign dbg_data_o = (dbg_addr_i == '0) ? '0 : regs[dbg_addr_i];

endmodule

`default_nettype wire

//--- rv_wb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_macros.svh"

module rv_wb (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  output logic                  wb_stall_o,
  // From memory stage
  input  rv_core_pkg::xlen_t    mem_pc_i,
  input  rv_core_pkg::instr_t   mem_instr_i,
  input  logic                  mem_bubble_i,
  input  rv_core_pkg::except_t  mem_exception_i,
  input  rv_core_pkg::xlen_t    mem_r_i,
  input  rv_core_pkg::xlen_t    mem_memadr_i,
  // From data memory
  input  logic                  dmem_ack_i,
  input  logic                  dmem_err_i,
  input  rv_core_pkg::xlen_t    dmem_q_i,
  input  logic                  dmem_misaligned_i,
  input  logic                  dmem_page_fault_i,
  // Retired instruction
  output rv_core_pkg::xlen_t    wb_pc_o,
  output rv_core_pkg::instr_t   wb_instr_o,
  output logic                  wb_bubble_o,
  output rv_core_pkg::except_t  wb_exception_o,
  output rv_core_pkg::xlen_t    wb_badaddr_o,
  // Register file write
  output rv_core_pkg::reg_idx_t wb_dst_o,
  output rv_core_pkg::xlen_t    wb_r_o,
  output logic                  wb_we_o
);

  import rv_core_pkg::*;

  opcode_e  opcode;
  funct3_t  funct3;
  reg_idx_t dst;
  except_t  exception;
  logic     is_load;
  logic     is_store;
  logic     mem_op;
  logic     mem_fault;
  logic     writes_rd;
  logic     reg_we;
  xlen_t    m_qs;
  xlen_t    m_data;

  assign opcode = opcode_e'(mem_instr_i[6:2]);
  assign funct3 = mem_instr_i[14:12];
  assign dst    = mem_instr_i[11:7];

  assign is_load  = ~mem_bubble_i & (opcode == OPC_LOAD);
  assign is_store = ~mem_bubble_i & (opcode == OPC_STORE);
  assign mem_op   = (is_load | is_store) & ~(|mem_exception_i);

  // Wait for ack or any fault
  assign wb_stall_o = mem_op &
                      ~(dmem_ack_i | dmem_err_i | dmem_misaligned_i | dmem_page_fault_i);

  ////////////////////
  // Exception merge
  ////////////////////

  always_comb
  begin
    exception = mem_exception_i;
    if (is_load)
    begin
      exception[`RV_CAUSE_MISALIGNED_LOAD]   |= dmem_misaligned_i;
      exception[`RV_CAUSE_LOAD_ACCESS_FAULT] |= dmem_err_i;
      exception[`RV_CAUSE_LOAD_PAGE_FAULT]   |= dmem_page_fault_i;
    end
    if (is_store)
    begin
      exception[`RV_CAUSE_MISALIGNED_STORE]   |= dmem_misaligned_i;
      exception[`RV_CAUSE_STORE_ACCESS_FAULT] |= dmem_err_i;
      exception[`RV_CAUSE_STORE_PAGE_FAULT]   |= dmem_page_fault_i;
    end
  end

  // Any memory cause picks the data address
  assign mem_fault = exception[`RV_CAUSE_MISALIGNED_LOAD]    |
                     exception[`RV_CAUSE_LOAD_ACCESS_FAULT]  |
                     exception[`RV_CAUSE_LOAD_PAGE_FAULT]    |
                     exception[`RV_CAUSE_MISALIGNED_STORE]   |
                     exception[`RV_CAUSE_STORE_ACCESS_FAULT] |
                     exception[`RV_CAUSE_STORE_PAGE_FAULT];

  ////////////////////
  // Load alignment
  ////////////////////

  assign m_qs = dmem_q_i >> {mem_memadr_i[1:0], 3'b000};

  always_comb
  begin
    unique case (funct3)
      3'b000:  m_data = {{(`RV_XLEN-8){m_qs[7]}}, m_qs[7:0]};
      3'b001:  m_data = {{(`RV_XLEN-16){m_qs[15]}}, m_qs[15:0]};
      3'b100:  m_data = {{(`RV_XLEN-8){1'b0}}, m_qs[7:0]};
      3'b101:  m_data = {{(`RV_XLEN-16){1'b0}}, m_qs[15:0]};
      // LW and anything else take the word
      default: m_data = dmem_q_i;
    endcase
  end

  // Opcodes without a destination
  always_comb
  begin
    unique case (opcode)
      OPC_STORE, OPC_STORE_FP, OPC_BRANCH, OPC_MISC_MEM: writes_rd = 1'b0;
      default: writes_rd = 1'b1;
    endcase
  end

  assign reg_we = ~mem_bubble_i & ~(|exception) & (|dst) & writes_rd;

  ////////////////////
  // Write-back registers
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      wb_pc_o        <= `RV_PC_INIT;
      wb_instr_o     <= INSTR_NOP;
      wb_bubble_o    <= 1'b1;
      wb_exception_o <= '0;
      wb_we_o        <= 1'b0;
    end
    else if (!wb_stall_o)
    begin
      wb_pc_o        <= mem_pc_i;
      wb_instr_o     <= mem_instr_i;
      wb_bubble_o    <= mem_bubble_i;
      wb_exception_o <= exception;
      wb_we_o        <= reg_we;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!wb_stall_o)
    begin
      wb_badaddr_o <= mem_fault ? mem_memadr_i : mem_pc_i;
      wb_dst_o     <= dst;
      wb_r_o       <= (opcode == OPC_LOAD) ? m_data : mem_r_i;
    end
  end

  // Memory stage holds its item while write-back waits
  stall_hold_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_stall_o |=> $stable(mem_pc_i) && $stable(mem_instr_i) && $stable(mem_memadr_i));

endmodule

`default_nettype wire

//--- rv_dmem.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_macros.svh"

module rv_dmem (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 dmem_req_i,
  input  logic                 dmem_we_i,
  input  rv_core_pkg::xlen_t   dmem_adr_i,
  input  rv_core_pkg::funct3_t dmem_size_i,
  input  rv_core_pkg::xlen_t   dmem_wdata_i,
  output logic                 dmem_ack_o,
  output rv_core_pkg::xlen_t   dmem_q_o,
  output logic                 dmem_err_o,
  output logic                 dmem_misaligned_o,
  output logic                 dmem_page_fault_o
);

  import rv_core_pkg::*;

  localparam int AW = $clog2(`RV_DMEM_WORDS);
  localparam int CW = $clog2(`RV_DMEM_LATENCY + 1);

  xlen_t         mem_array [`RV_DMEM_WORDS];
  dmem_state_e   state;
  logic [CW-1:0] wait_cnt;
  logic          ack_q;
  logic          err_q;
  logic          mis_q;
  logic          pf_q;
  logic          misaligned;
  logic          out_of_range;
  logic          guarded;
  logic          respond;
  logic [AW-1:0] word_idx;
  logic [3:0]    byte_en;
  xlen_t         wdata_lane;

  ////////////////////
  // Access decode
  ////////////////////

  always_comb
  begin
    unique case (dmem_size_i[1:0])
      2'b00:   misaligned = 1'b0;
      2'b01:   misaligned = dmem_adr_i[0];
      default: misaligned = |dmem_adr_i[1:0];
    endcase
  end

  // Beyond the array
  assign out_of_range = dmem_adr_i >= xlen_t'(`RV_DMEM_WORDS * 4);
  // Upper part of the array is guarded
  assign guarded      = ~out_of_range & (dmem_adr_i >= xlen_t'(`RV_DMEM_GUARD));
  assign word_idx     = dmem_adr_i[AW+1:2];

  // Byte lanes for the store size
  always_comb
  begin
    unique case (dmem_size_i[1:0])
      2'b00:   byte_en = 4'b0001 << dmem_adr_i[1:0];
      2'b01:   byte_en = 4'b0011 << dmem_adr_i[1:0];
      default: byte_en = 4'b1111;
    endcase
  end

  assign wdata_lane = dmem_wdata_i << {dmem_adr_i[1:0], 3'b000};

  // Last wait cycle, the access happens here
  assign respond = (state == DM_WAIT) && (wait_cnt == '0);

  ////////////////////
  // Handshake FSM
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state    <= DM_IDLE;
      wait_cnt <= '0;
      ack_q    <= 1'b0;
      err_q    <= 1'b0;
      mis_q    <= 1'b0;
      pf_q     <= 1'b0;
    end
    else
    begin
      unique case (state)
        DM_IDLE:
          if (dmem_req_i)
          begin
            state    <= DM_WAIT;
            wait_cnt <= CW'(`RV_DMEM_LATENCY - 1);
          end
        DM_WAIT:
          if (respond)
          begin
            state <= DM_ACK;
            ack_q <= 1'b1;
            err_q <= out_of_range;
            mis_q <= misaligned;
            pf_q  <= guarded;
          end
          else
          begin
            wait_cnt <= wait_cnt - 1'b1;
          end
        // Hold until the requester lets go
        DM_ACK:
          if (!dmem_req_i)
          begin
            state <= DM_IDLE;
            ack_q <= 1'b0;
            err_q <= 1'b0;
            mis_q <= 1'b0;
            pf_q  <= 1'b0;
          end
        default: state <= DM_IDLE;
      endcase
    end
  end

  // Storage and read word
  always_ff @(posedge clk_i)
  begin
    if (respond)
    begin
      if (dmem_we_i && !(misaligned || out_of_range || guarded))
      begin
        for (int i = 0; i < 4; i++)
        begin
          if (byte_en[i])
            mem_array[word_idx][8*i +: 8] <= wdata_lane[8*i +: 8];
        end
      end
      dmem_q_o <= mem_array[word_idx];
    end
  end

  // Response hidden once req drops
  assign dmem_ack_o        = ack_q & dmem_req_i;
  assign dmem_err_o        = err_q & dmem_req_i;
  assign dmem_misaligned_o = mis_q & dmem_req_i;
  assign dmem_page_fault_o = pf_q & dmem_req_i;

  // Requester may not withdraw early
  req_hold_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    dmem_req_i && !dmem_ack_o |=> dmem_req_i);

endmodule

`default_nettype wire

//--- rv_mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_macros.svh"

module rv_mem_stage (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // From execute
  input  rv_core_pkg::xlen_t   ex_pc_i,
  input  rv_core_pkg::instr_t  ex_instr_i,
  input  logic                 ex_bubble_i,
  input  rv_core_pkg::xlen_t   ex_r_i,
  input  rv_core_pkg::xlen_t   ex_wdata_i,
  input  rv_core_pkg::except_t ex_exception_i,
  input  logic                 stall_i,
  // To write-back
  output rv_core_pkg::xlen_t   mem_pc_o,
  output rv_core_pkg::instr_t  mem_instr_o,
  output logic                 mem_bubble_o,
  output rv_core_pkg::xlen_t   mem_r_o,
  output rv_core_pkg::xlen_t   mem_memadr_o,
  output rv_core_pkg::except_t mem_exception_o,
  // Data memory requester
  output logic                 dmem_req_o,
  output logic                 dmem_we_o,
  output rv_core_pkg::xlen_t   dmem_adr_o,
  output rv_core_pkg::funct3_t dmem_size_o,
  output rv_core_pkg::xlen_t   dmem_wdata_o,
  input  logic                 dmem_ack_i
);

  import rv_core_pkg::*;

  opcode_e opcode;
  xlen_t   mem_wdata;
  logic    is_mem;
  // Access for this instruction already retired
  logic    done;

  assign opcode = opcode_e'(mem_instr_o[6:2]);
  // Only clean loads and stores touch memory
  assign is_mem = ~mem_bubble_o & ~(|mem_exception_o) &
                  ((opcode == OPC_LOAD) || (opcode == OPC_STORE));

  ////////////////////
  // Pipeline register
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      mem_pc_o        <= `RV_PC_INIT;
      mem_instr_o     <= INSTR_NOP;
      mem_bubble_o    <= 1'b1;
      mem_exception_o <= '0;
    end
    else if (!stall_i)
    begin
      mem_pc_o        <= ex_pc_i;
      mem_instr_o     <= ex_instr_i;
      mem_bubble_o    <= ex_bubble_i;
      mem_exception_o <= ex_exception_i;
    end
  end

  // Result and store data
  always_ff @(posedge clk_i)
  begin
    if (!stall_i)
    begin
      mem_r_o   <= ex_r_i;
      mem_wdata <= ex_wdata_i;
    end
  end

  ////////////////////
  // Four-phase request
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      dmem_req_o <= 1'b0;
      done       <= 1'b0;
    end
    // New instruction enters, start clean
    else if (!stall_i)
    begin
      dmem_req_o <= 1'b0;
      done       <= 1'b0;
    end
    // Drop req on the edge that sees ack
    else if (dmem_req_o && dmem_ack_i)
    begin
      dmem_req_o <= 1'b0;
      done       <= 1'b1;
    end
    else if (is_mem && !done && !dmem_ack_i)
    begin
      dmem_req_o <= 1'b1;
    end
  end

  // Address is the ALU result
  assign mem_memadr_o = mem_r_o;
  assign dmem_adr_o   = mem_r_o;
  assign dmem_we_o    = (opcode == OPC_STORE);
  assign dmem_size_o  = funct3_t'(mem_instr_o[14:12]);
  assign dmem_wdata_o = mem_wdata;

  // Memory answers a new req within its latency
  req_ack_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(dmem_req_o) |-> ##[1:(`RV_DMEM_LATENCY + 1)] dmem_ack_i);

endmodule

`default_nettype wire

//--- rv_core_pkg.sv
`default_nettype none

`include "rv_core_macros.svh"

package rv_core_pkg;

  ////////////////////
  // Vector types
  ////////////////////

  typedef logic [`RV_XLEN-1:0]     xlen_t;
  typedef logic [`RV_ILEN-1:0]     instr_t;
  typedef logic [4:0]              reg_idx_t;
  typedef logic [`RV_EXC_SIZE-1:0] except_t;
  // Access size and signedness
  typedef logic [2:0]              funct3_t;

  // Major opcodes, instruction bits 6:2
  typedef enum logic [4:0] {
    OPC_LOAD     = 5'b00000,
    OPC_MISC_MEM = 5'b00011,
    OPC_OP_IMM   = 5'b00100,
    OPC_STORE    = 5'b01000,
    OPC_STORE_FP = 5'b01001,
    OPC_OP       = 5'b01100,
    OPC_LUI      = 5'b01101,
    OPC_BRANCH   = 5'b11000
  } opcode_e;

  // Data memory FSM
  typedef enum logic [1:0] {
    DM_IDLE,
    DM_WAIT,
    DM_ACK
  } dmem_state_e;

  // addi x0, x0, 0
  localparam instr_t INSTR_NOP = 32'h0000_0013;

endpackage

`default_nettype wire

//--- rv_core_macros.svh
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

// Datapath widths
`define RV_XLEN 32
`define RV_ILEN 32

// PC value out of reset
`define RV_PC_INIT 'h200

// Exception vector, one bit per cause
`define RV_EXC_SIZE 16

// Cause indices used by the memory path
`define RV_CAUSE_MISALIGNED_LOAD    4
`define RV_CAUSE_LOAD_ACCESS_FAULT  5
`define RV_CAUSE_MISALIGNED_STORE   6
`define RV_CAUSE_STORE_ACCESS_FAULT 7
`define RV_CAUSE_LOAD_PAGE_FAULT    13
`define RV_CAUSE_STORE_PAGE_FAULT   15

// Data memory geometry, 64 words gives bytes 0 to 255
`define RV_DMEM_WORDS   64
// First guarded byte address
`define RV_DMEM_GUARD   'h80
// Cycles from req seen to ack
`define RV_DMEM_LATENCY 2

`endif
